/* tb/golden_vectors.txt */
none_resp      response 7010500000000000000 00 0 0
guard_req      request  7010000000000000000 00 0 0
guard_ok       response 7010500000000000000 00 1 1
guard_toggle   response 7018500000000000000 00 1 1
guard_bad      response 7010400000000000000 00 1 0
guard_data     response 7010500000000000001 00 1 0
rd_req         request  6014010180100000000 00 0 0
rd_ok          response 5814310180112345678 00 2 1
rd_bad_index   response 5814310170112345678 00 2 0
rd_bad_cmd     response 5816010180100000000 00 2 0
wr_req         request  602232000030000ABCD 00 0 0
wr_ok          response 5826020000300000000 00 3 1
wr_bad_cmd     response 5824320000300000000 00 3 0
wr_bad_node    response 5816020000300000000 00 3 0
trim_start     trim     0000000000000000000 00 0 0
trim_ok        response 555AAAAAA03AAAAAAAA 03 4 1
trim_bad_bus   response 555AAAAAA03AAAAAAAA 04 4 0
trim_bus7      response 555AAAAAA07AAAAAAAA 07 4 1
echo_req       request  123456789ABCDEF0011 00 0 0
echo_ok        response 123456789ABCDEF00FF 00 5 1
echo_bad_data  response 123456789AB11EF0011 00 5 0
echo_new_req   collide  2220000000000000000 00 0 0
echo_collide   response 123456789ABCDEF0022 00 5 1
b2b_first      burst    2220000000000000001 00 5 1
b2b_second     burst    2230000000000000000 00 5 0
b2b_third      response 2220000000000000003 00 5 1

/* build.f */
src/mopsCheckPkg.sv
src/requestCapture.sv
src/ruleDecode.sv
src/responseCompare.sv
src/checkTally.sv
src/mopsCheckTop.sv
tb/tbMopsCheck.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tbMopsCheck
FILELIST  := build.f
OBJDIR    := obj_dir
LINTFLAGS := --lint-only --timing -sv
SIMFLAGS  := --binary --timing -sv -j 0 --Mdir $(OBJDIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

/* tb/tbMopsCheck.sv */
`timescale 1ns/1ps

module tbMopsCheck;

  localparam int CountWidth  = 16;
  localparam int NameBytes   = 16;
  localparam int VerdictWait = 20;

  typedef logic [8*NameBytes-1:0] nameT;

  logic                  clk;
  logic                  rst;
  logic                  reqMsg;
  logic                  trimStart;
  mopsCheckPkg::msgT     requestData;
  logic                  respMsg;
  mopsCheckPkg::msgT     responseData;
  logic [7:0]            busId;
  logic                  checkValid;
  logic                  checkGood;
  mopsCheckPkg::ruleT    checkRule;
  logic [CountWidth-1:0] passCount;
  logic [CountWidth-1:0] failCount;

  // expected verdicts in issue order
  nameT               expName[$];
  mopsCheckPkg::ruleT expRule[$];
  logic               expGood[$];
  int                 expCycle[$];

  int                 cycleCount;
  int                 runPass;
  int                 runFail;
  bit                 countDue;
  nameT               lastName;
  mopsCheckPkg::ruleT wantRule;
  logic               wantGood;
  int                 wantCycle;

  mopsCheckTop #(
    .CountWidth (CountWidth)
  ) i_mopsCheckTop
  (
    .clk          (clk),
    .rst          (rst),
    .reqMsg       (reqMsg),
    .trimStart    (trimStart),
    .requestData  (requestData),
    .respMsg      (respMsg),
    .responseData (responseData),
    .busId        (busId),
    .checkValid   (checkValid),
    .checkGood    (checkGood),
    .checkRule    (checkRule),
    .passCount    (passCount),
    .failCount    (failCount)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #20 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
  end

  task automatic abortRun();
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkRuleTask(input nameT caseName, input mopsCheckPkg::ruleT expected,
                               input mopsCheckPkg::ruleT actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0s: rule expected %0s actual %0s", caseName, expected.name(),
               actual.name());
      abortRun();
    end
  endtask

  task automatic checkBitTask(input nameT caseName, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0s: checkGood expected %b actual %b", caseName, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkCountTask(input nameT caseName, input string what,
                                input logic [CountWidth-1:0] expected,
                                input logic [CountWidth-1:0] actual);
    if (actual !== expected)
    begin
      $display("[FAIL] %0s: %0s expected %0d actual %0d", caseName, what, expected, actual);
      abortRun();
    end
  endtask

  task automatic clearStrobes();
    reqMsg    <= 1'b0;
    trimStart <= 1'b0;
    respMsg   <= 1'b0;
  endtask

  task automatic drainVerdicts();
    int waited;
    waited = 0;
    while (expRule.size() != 0 && waited < VerdictWait)
    begin
      @(posedge clk);
      clearStrobes();
      waited++;
    end
    if (expRule.size() != 0)
    begin
      $display("no verdict arrived within %0d cycles of a response", VerdictWait);
      abortRun();
    end
  endtask

  // counters lag checkValid by one cycle
  always @(negedge clk)
  begin
    if (countDue)
    begin
      checkCountTask(lastName, "passCount", CountWidth'(runPass), passCount);
      checkCountTask(lastName, "failCount", CountWidth'(runFail), failCount);
      countDue = 1'b0;
    end
    if (checkValid === 1'b1)
    begin
      if (expRule.size() == 0)
      begin
        $display("checkValid pulsed with no response outstanding");
        abortRun();
      end
      else
      begin
        lastName  = expName.pop_front();
        wantRule  = expRule.pop_front();
        wantGood  = expGood.pop_front();
        wantCycle = expCycle.pop_front();
        if (cycleCount != wantCycle)
        begin
          $display("[FAIL] %0s: verdict cycle expected %0d actual %0d", lastName, wantCycle,
                   cycleCount);
          abortRun();
        end
        checkRuleTask(lastName, wantRule, checkRule);
        checkBitTask(lastName, wantGood, checkGood);
        if (wantGood)
        begin
          runPass++;
        end
        else
        begin
          runFail++;
        end
        countDue = 1'b1;
      end
    end
  end

  initial
  begin
    int                fd;
    int                code;
    int                waited;
    int                ruleCode;
    int                goodCode;
    nameT              caseName;
    nameT              kind;
    mopsCheckPkg::msgT msg;
    logic [7:0]        busVal;
    bit                joinNext;
    bit                done;

    rst          <= 1'b0;
    reqMsg       <= 1'b0;
    trimStart    <= 1'b0;
    requestData  <= '0;
    respMsg      <= 1'b0;
    responseData <= '0;
    busId        <= 8'h00;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    checkCountTask(nameT'("after_reset"), "passCount", '0, passCount);
    checkCountTask(nameT'("after_reset"), "failCount", '0, failCount);

    fd = $fopen("tb/golden_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open tb/golden_vectors.txt");
      abortRun();
    end

    done     = 1'b0;
    joinNext = 1'b0;
    while (!done)
    begin
      code = $fscanf(fd, "%s %s %h %h %d %d", caseName, kind, msg, busVal, ruleCode, goodCode);
      if (code != 6)
      begin
        if ($feof(fd))
        begin
          done = 1'b1;
        end
        else
        begin
          $display("malformed line in golden file");
          abortRun();
        end
      end
      else
      begin
        // a collide line shares its edge with the next line
        if (!joinNext)
        begin
          @(posedge clk);
          clearStrobes();
        end
        joinNext = 1'b0;
        if (kind == nameT'("request") || kind == nameT'("collide"))
        begin
          reqMsg      <= 1'b1;
          requestData <= msg;
          joinNext    = (kind == nameT'("collide"));
        end
        else if (kind == nameT'("trim"))
        begin
          trimStart <= 1'b1;
        end
        else if (kind == nameT'("response") || kind == nameT'("burst"))
        begin
          respMsg      <= 1'b1;
          responseData <= msg;
          busId        <= busVal;
          expName.push_back(caseName);
          expRule.push_back(mopsCheckPkg::ruleT'(ruleCode));
          expGood.push_back(goodCode != 0);
          // sampled next edge, verdict registered one edge later
          expCycle.push_back(cycleCount + 3);
          if (kind == nameT'("response"))
          begin
            drainVerdicts();
          end
        end
        else
        begin
          $display("unknown line kind in golden file for case %0s", caseName);
          abortRun();
        end
      end
    end
    $fclose(fd);
    drainVerdicts();

    waited = 0;
    while (countDue && waited < 4)
    begin
      @(posedge clk);
      waited++;
    end
    if (countDue)
    begin
      $display("counter check after the last verdict never ran");
      abortRun();
    end
    else
    begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* src/mopsCheckTop.sv */
`timescale 1ns/1ps

module mopsCheckTop
#(
  parameter int CountWidth = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reqMsg,
  input  logic                  trimStart,
  input  mopsCheckPkg::msgT     requestData,
  input  logic                  respMsg,
  input  mopsCheckPkg::msgT     responseData,
  input  logic [7:0]            busId,
  output logic                  checkValid,
  output logic                  checkGood,
  output mopsCheckPkg::ruleT    checkRule,
  output logic [CountWidth-1:0] passCount,
  output logic [CountWidth-1:0] failCount
);

  mopsCheckPkg::msgT  reqSnap;
  mopsCheckPkg::msgT  respReg;
  logic [7:0]         busIdReg;
  logic               respPending;
  logic               requestSeen;
  mopsCheckPkg::ruleT rule;

  requestCapture i_requestCapture
  (
    .clk          (clk),
    .rst          (rst),
    .reqMsg       (reqMsg),
    .trimStart    (trimStart),
    .requestData  (requestData),
    .respMsg      (respMsg),
    .responseData (responseData),
    .busId        (busId),
    .reqSnap      (reqSnap),
    .respReg      (respReg),
    .busIdReg     (busIdReg),
    .respPending  (respPending),
    .requestSeen  (requestSeen)
  );

  ruleDecode i_ruleDecode
  (
    .reqSnap     (reqSnap),
    .requestSeen (requestSeen),
    .rule        (rule)
  );

  responseCompare i_responseCompare
  (
    .clk         (clk),
    .rst         (rst),
    .respPending (respPending),
    .rule        (rule),
    .reqSnap     (reqSnap),
    .respReg     (respReg),
    .busIdReg    (busIdReg),
    .checkValid  (checkValid),
    .checkGood   (checkGood),
    .checkRule   (checkRule)
  );

  checkTally #(
    .CountWidth (CountWidth)
  ) i_checkTally
  (
    .clk        (clk),
    .rst        (rst),
    .checkValid (checkValid),
    .checkGood  (checkGood),
    .passCount  (passCount),
    .failCount  (failCount)
  );

endmodule

/* src/checkTally.sv */
`timescale 1ns/1ps

module checkTally
#(
  parameter int CountWidth = 16
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  checkValid,
  input  logic                  checkGood,
  output logic [CountWidth-1:0] passCount,
  output logic [CountWidth-1:0] failCount
);

  logic passFull;
  logic failFull;

  assign passFull = &passCount;
  assign failFull = &failCount;

  // counters hold at all ones
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      passCount <= '0;
      failCount <= '0;
    end
    else if (checkValid)
    begin
      if (checkGood && !passFull)
      begin
        passCount <= passCount + 1'b1;
      end
      else if (!checkGood && !failFull)
      begin
        failCount <= failCount + 1'b1;
      end
    end
  end

endmodule

/* src/responseCompare.sv */
`timescale 1ns/1ps

module responseCompare
(
  input  logic               clk,
  input  logic               rst,
  input  logic               respPending,
  input  mopsCheckPkg::ruleT rule,
  input  mopsCheckPkg::msgT  reqSnap,
  input  mopsCheckPkg::msgT  respReg,
  input  logic [7:0]         busIdReg,
  output logic               checkValid,
  output logic               checkGood,
  output mopsCheckPkg::ruleT checkRule
);

  logic [11:0]       reqCob;
  logic [11:0]       respCob;
  logic [7:0]        respCmd;
  logic [11:0]       sdoRespCob;
  logic              sdoAddrOk;
  logic              guardOk;
  logic              trimOk;
  logic              echoOk;
  logic              verdict;
  mopsCheckPkg::msgT trimExpect;

  assign reqCob  = reqSnap[mopsCheckPkg::CobIdLsb +: 12];
  assign respCob = respReg[mopsCheckPkg::CobIdLsb +: 12];
  assign respCmd = respReg[mopsCheckPkg::CmdLsb +: 8];

  // server reply goes out on 580h plus node id
  assign sdoRespCob = mopsCheckPkg::SdoTxBase + {5'd0, reqCob[6:0]};

  assign sdoAddrOk = (respCob == sdoRespCob)
    && (respReg[mopsCheckPkg::IndexLsb +: 16] == reqSnap[mopsCheckPkg::IndexLsb +: 16])
    && (respReg[mopsCheckPkg::SubLsb +: 8] == reqSnap[mopsCheckPkg::SubLsb +: 8]);

  assign guardOk = (respCob == reqCob)
    && (respCmd[3:0] == mopsCheckPkg::GuardStateNibble)
    && (respReg[mopsCheckPkg::IndexLsb +: 16] == 16'd0)
    && (respReg[mopsCheckPkg::SubLsb +: 8] == 8'd0)
    && (respReg[mopsCheckPkg::DataLsb +: 32] == 32'd0);

  // each bus echoes its own id in the subindex
  always_comb
  begin
    trimExpect = mopsCheckPkg::TrimPattern;
    trimExpect[mopsCheckPkg::SubLsb +: 8] = busIdReg;
  end

  assign trimOk = (respReg == trimExpect);
  assign echoOk = (respReg[mopsCheckPkg::MsgWidth-1:8] == reqSnap[mopsCheckPkg::MsgWidth-1:8]);

  always_comb
  begin
    case (rule)
      mopsCheckPkg::RuleGuard:    verdict = guardOk;
      mopsCheckPkg::RuleSdoRead:  verdict = sdoAddrOk && respCmd == mopsCheckPkg::CmdReadResp;
      mopsCheckPkg::RuleSdoWrite: verdict = sdoAddrOk && respCmd == mopsCheckPkg::CmdWriteAck;
      mopsCheckPkg::RuleTrim:     verdict = trimOk;
      mopsCheckPkg::RuleEcho:     verdict = echoOk;
      default:                    verdict = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      checkValid <= 1'b0;
      checkGood  <= 1'b0;
      checkRule  <= mopsCheckPkg::RuleNone;
    end
    else
    begin
      checkValid <= respPending;
      if (respPending)
      begin
        checkGood <= verdict;
        checkRule <= rule;
      end
    end
  end

endmodule

/* src/ruleDecode.sv */
`timescale 1ns/1ps

module ruleDecode
(
  input  mopsCheckPkg::msgT  reqSnap,
  input  logic               requestSeen,
  output mopsCheckPkg::ruleT rule
);

  logic [11:0] cobId;
  logic [7:0]  cmd;
  logic [6:0]  nodeId;
  logic        lowerZero;
  logic        guardRange;
  logic        sdoRxRange;

  assign cobId  = reqSnap[mopsCheckPkg::CobIdLsb +: 12];
  assign cmd    = reqSnap[mopsCheckPkg::CmdLsb +: 8];
  assign nodeId = cobId[6:0];

  // everything below the cob-id
  assign lowerZero = (reqSnap[mopsCheckPkg::CobIdLsb-1:0] == '0);

  // node id zero is not a valid node
  assign guardRange = (cobId[11:7] == mopsCheckPkg::NodeGuardBase[11:7]) && (nodeId != 7'd0);
  assign sdoRxRange = (cobId[11:7] == mopsCheckPkg::SdoRxBase[11:7]) && (nodeId != 7'd0);

  always_comb
  begin
    if (!requestSeen)
    begin
      rule = mopsCheckPkg::RuleNone;
    end
    else if (reqSnap == mopsCheckPkg::TrimPattern)
    begin
      rule = mopsCheckPkg::RuleTrim;
    end
    else if (guardRange && lowerZero)
    begin
      rule = mopsCheckPkg::RuleGuard;
    end
    else if (sdoRxRange && cmd == mopsCheckPkg::CmdReadReq)
    begin
      rule = mopsCheckPkg::RuleSdoRead;
    end
    else if (sdoRxRange && cmd == mopsCheckPkg::CmdWriteReq)
    begin
      rule = mopsCheckPkg::RuleSdoWrite;
    end
    else
    begin
      rule = mopsCheckPkg::RuleEcho;
    end
  end

endmodule

/* src/requestCapture.sv */
`timescale 1ns/1ps

module requestCapture
(
  input  logic              clk,
  input  logic              rst,
  input  logic              reqMsg,
  input  logic              trimStart,
  input  mopsCheckPkg::msgT requestData,
  input  logic              respMsg,
  input  mopsCheckPkg::msgT responseData,
  input  logic [7:0]        busId,
  output mopsCheckPkg::msgT reqSnap,
  output mopsCheckPkg::msgT respReg,
  output logic [7:0]        busIdReg,
  output logic              respPending,
  output logic              requestSeen
);

  mopsCheckPkg::msgT liveReq;
  logic              liveSeen;

  // a new request wins over the trim strobe
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      liveReq  <= '0;
      liveSeen <= 1'b0;
    end
    else if (reqMsg)
    begin
      liveReq  <= requestData;
      liveSeen <= 1'b1;
    end
    else if (trimStart)
    begin
      liveReq  <= mopsCheckPkg::TrimPattern;
      liveSeen <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      respPending <= 1'b0;
      requestSeen <= 1'b0;
    end
    else
    begin
      respPending <= respMsg;
      if (respMsg)
      begin
        requestSeen <= liveSeen;
      end
    end
  end

  // snapshot uses the request held before this edge
  always_ff @(posedge clk)
  begin
    if (respMsg)
    begin
      reqSnap  <= liveReq;
      respReg  <= responseData;
      busIdReg <= busId;
    end
  end

endmodule

/* src/mopsCheckPkg.sv */
package mopsCheckPkg;

  localparam int MsgWidth = 76;

  typedef logic [MsgWidth-1:0] msgT;

  // cob-id sits in the top 12 bits
  localparam int CobIdLsb = 64;
  localparam int CmdLsb   = 56;
  localparam int IndexLsb = 40;
  localparam int SubLsb   = 32;
  localparam int DataLsb  = 0;

  // cob-id bases with the node id in the low 7 bits
  localparam logic [11:0] NodeGuardBase = 12'h700;
  localparam logic [11:0] SdoRxBase     = 12'h600;
  localparam logic [11:0] SdoTxBase     = 12'h580;

  // sdo command bytes
  localparam logic [7:0] CmdReadReq  = 8'h40;
  localparam logic [7:0] CmdReadResp = 8'h43;
  localparam logic [7:0] CmdWriteReq = 8'h23;
  localparam logic [7:0] CmdWriteAck = 8'h60;

  // node state expected in a guard reply
  localparam logic [3:0] GuardStateNibble = 4'h5;

  // oscillator trim loopback pattern
  localparam msgT TrimPattern = 76'h555_AAAA_AAAA_AAAA_AAAA;

  typedef enum logic [2:0]
  {
    RuleNone     = 3'd0,
    RuleGuard    = 3'd1,
    RuleSdoRead  = 3'd2,
    RuleSdoWrite = 3'd3,
    RuleTrim     = 3'd4,
    RuleEcho     = 3'd5
  } ruleT;

endpackage
